//--- design/rf_pkg.sv
package rf_pkg;

   // Bits per register, also the counter length of one access
   localparam int XLEN = 32;

   // 32 GPRs, then the four machine CSRs
   localparam int RF_REGS = 36;

   // First register number of the CSR block
   localparam int CSR_BASE = 32;

   // Fixed upper address bits of a CSR
   localparam logic [3:0] CSR_TAG = 4'b1000;

   // CSR index within the CSR block
   localparam logic [1:0] CSR_MSCRATCH = 2'd0;
   localparam logic [1:0] CSR_MTVEC    = 2'd1;
   localparam logic [1:0] CSR_MEPC     = 2'd2;
   localparam logic [1:0] CSR_MTVAL    = 2'd3;

   // One register file address, seen as a GPR or as a CSR
   typedef union packed {
      struct packed {
         logic       zero;
         logic [4:0] idx;
      } gpr;
      struct packed {
         logic [3:0] tag;
         logic [1:0] idx;
      } csr;
   } rf_addr_u;

   // RAM words needed for all registers at word width w
   function automatic int ram_words(input int w);
      return RF_REGS * (XLEN / w);
   endfunction

   // RAM address width at word width w
   function automatic int ram_aw(input int w);
      return $clog2(ram_words(w));
   endfunction

   function automatic rf_addr_u gpr_addr(input logic [4:0] idx);
      rf_addr_u a;
      a.gpr.zero = 1'b0;
      a.gpr.idx  = idx;
      return a;
   endfunction

   function automatic rf_addr_u csr_addr(input logic [1:0] idx);
      rf_addr_u a;
      a.csr.tag = CSR_TAG;
      a.csr.idx = idx;
      return a;
   endfunction

endpackage

//--- design/rf_ifs.sv
// Bit-serial register file ports between the core mapping and the RAM adapter
interface rf_port_bus
   import rf_pkg::*;
();
   // Write port 0, rd or MTVAL
   rf_addr_u wreg0;
   logic     wen0;
   logic     wdata0;
   // Write port 1, CSR or MEPC
   rf_addr_u wreg1;
   logic     wen1;
   logic     wdata1;
   // Read ports, rs1 and rs2/CSR
   rf_addr_u rreg0;
   rf_addr_u rreg1;
   logic     rdata0;
   logic     rdata1;

   modport core (
      output wreg0, wreg1, wen0, wen1, wdata0, wdata1, rreg0, rreg1,
      input  rdata0, rdata1
   );

   modport ram (
      input  wreg0, wreg1, wen0, wen1, wdata0, wdata1, rreg0, rreg1,
      output rdata0, rdata1
   );
endinterface

// Word-wide RAM access, one write and one read per cycle
interface rf_ram_bus
   import rf_pkg::*;
#(
   parameter int W = 4
) ();
   logic [ram_aw(W)-1:0] waddr;
   logic [W-1:0]         wdata;
   logic                 wen;
   logic [ram_aw(W)-1:0] raddr;
   // Valid one cycle after raddr
   logic [W-1:0]         rdata;

   modport ctrl (output waddr, wdata, wen, raddr, input rdata);

   modport mem (input waddr, wdata, wen, raddr, output rdata);
endinterface

//--- design/serv_rf_if.sv
module serv_rf_if
   import rf_pkg::*;
#(
   parameter int WITH_CSR = 1
) (
   input  logic       i_cnt_en,
   // Trap entry and return
   input  logic       i_trap,
   input  logic       i_mret,
   input  logic       i_mepc,
   input  logic       i_mem_op,
   input  logic       i_bufreg_q,
   input  logic       i_bad_pc,
   output logic       o_csr_pc,
   // CSR access
   input  logic       i_csr_en,
   input  logic [1:0] i_csr_addr,
   input  logic       i_csr,
   output logic       o_csr,
   // rd writeback sources
   input  logic       i_rd_wen,
   input  logic [4:0] i_rd_waddr,
   input  logic       i_ctrl_rd,
   input  logic       i_alu_rd,
   input  logic       i_rd_alu_en,
   input  logic       i_csr_rd,
   input  logic       i_rd_csr_en,
   input  logic       i_mem_rd,
   // Source registers
   input  logic [4:0] i_rs1_raddr,
   output logic       o_rs1,
   input  logic [4:0] i_rs2_raddr,
   output logic       o_rs2,
   // Toward the RAM adapter
   rf_port_bus.core   rf
);

   logic rd_wen;
   logic rd;

   // x0 is never written
   assign rd_wen = i_rd_wen & (|i_rd_waddr);

   // Read port 0 is always rs1
   assign rf.rreg0 = gpr_addr(i_rs1_raddr);
   assign o_rs1    = rf.rdata0;
   assign o_rs2    = rf.rdata1;

   generate
      if (WITH_CSR != 0) begin : g_csr
         logic mtval;

         // OR of all enabled rd sources
         assign rd = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) |
                     (i_csr_rd & i_rd_csr_en) | i_mem_rd;

         // Faulting address for loads/stores, else the bad PC
         assign mtval = i_mem_op ? i_bufreg_q : i_bad_pc;

         // Port 0 rd, or MTVAL on trap
         assign rf.wdata0 = i_trap ? mtval : rd;
         assign rf.wreg0  = i_trap ? csr_addr(CSR_MTVAL) : gpr_addr(i_rd_waddr);
         assign rf.wen0   = i_cnt_en & (i_trap | rd_wen);

         // Port 1 CSR data, or MEPC on trap
         assign rf.wdata1 = i_trap ? i_mepc : i_csr;
         assign rf.wreg1  = csr_addr(i_trap ? CSR_MEPC : i_csr_addr);
         assign rf.wen1   = i_cnt_en & (i_trap | i_csr_en);

         // Read port 1 priority
         // trap > mret > CSR > rs2
         always_comb begin
            if (i_trap) begin
               rf.rreg1 = csr_addr(CSR_MTVEC);
            end else if (i_mret) begin
               rf.rreg1 = csr_addr(CSR_MEPC);
            end else if (i_csr_en) begin
               rf.rreg1 = csr_addr(i_csr_addr);
            end else begin
               rf.rreg1 = gpr_addr(i_rs2_raddr);
            end
         end

         // Old CSR value only during a CSR access
         assign o_csr    = rf.rdata1 & i_csr_en;
         // MTVEC on trap, MEPC on mret
         assign o_csr_pc = rf.rdata1;
      end else begin : g_gpr
         // No CSR source for rd
         assign rd = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) | i_mem_rd;

         assign rf.wdata0 = rd;
         assign rf.wreg0  = gpr_addr(i_rd_waddr);
         assign rf.wen0   = i_cnt_en & rd_wen;

         // Second write port idle
         assign rf.wdata1 = 1'b0;
         assign rf.wreg1  = gpr_addr(5'd0);
         assign rf.wen1   = 1'b0;

         assign rf.rreg1 = gpr_addr(i_rs2_raddr);

         assign o_csr    = 1'b0;
         assign o_csr_pc = 1'b0;
      end
   endgenerate

endmodule

//--- design/rf_ram_if.sv
module rf_ram_if
   import rf_pkg::*;
#(
   parameter int W        = 4,
   parameter int WITH_CSR = 1
) (
   input  logic    i_clk,
   input  logic    i_reset,
   input  logic    i_rreq,
   input  logic    i_cnt_en,
   output logic    o_ready,
   rf_port_bus.ram rf,
   rf_ram_bus.ctrl ram
);

   localparam int L2W = $clog2(W);
   // Words per register
   localparam int WPR = XLEN / W;
   localparam int AW  = ram_aw(W);
   localparam int CW  = $clog2(XLEN);

   // Request timer
   logic           rreq_q;

   // Bit position within the register
   logic [CW-1:0]  cnt;
   logic [L2W-1:0] bit_idx;
   logic [CW-1:0]  word_idx;
   logic           last_word;

   // Read side
   logic           rd_issue0;
   logic           rd_issue1;
   logic [CW-1:0]  rd_word;
   logic           rtrig0;
   logic           rtrig1;
   logic [W-1:0]   rdata0_q;
   logic [W-1:0]   rdata1_q;

   // Write side
   logic           wr_fill;
   logic           wtrig0;
   logic           wtrig1;
   logic           wen0_q;
   logic           wen1_q;
   logic [W-1:0]   wsr0;
   logic [W-1:0]   wsr1;
   logic [W-1:0]   wword1;
   logic [AW-1:0]  wrow0;
   logic [AW-1:0]  wrow1;

   // RAM row of one word of a register
   function automatic logic [AW-1:0] row(input rf_addr_u a, input logic [CW-1:0] word);
      logic [5:0] reg_num;
      if ((WITH_CSR != 0) && a.gpr.zero) begin
         reg_num = 6'(CSR_BASE) + 6'(a.csr.idx);
      end else begin
         reg_num = {1'b0, a.gpr.idx};
      end
      return AW'(reg_num * WPR) + AW'(word);
   endfunction

   assign bit_idx   = cnt[L2W-1:0];
   assign word_idx  = cnt >> L2W;
   assign last_word = (word_idx == CW'(WPR - 1));

   // Port 0 reads two cycles before its word is needed
   assign rd_issue0 = rreq_q | (i_cnt_en & (bit_idx == L2W'(W - 2)) & ~last_word);
   // Port 1 one cycle before, bit 0 taken straight from RAM
   assign rd_issue1 = o_ready | (i_cnt_en & (bit_idx == L2W'(W - 1)) & ~last_word);

   // First word before counting, then the next word
   assign rd_word   = (i_cnt_en & ~last_word) ? word_idx + 1'b1 : '0;
   assign ram.raddr = rd_issue1 ? row(rf.rreg1, rd_word) : row(rf.rreg0, rd_word);

   assign rf.rdata0 = rdata0_q[0];
   assign rf.rdata1 = rtrig1 ? ram.rdata[0] : rdata1_q[0];

   // Last bit of a write word
   assign wr_fill = i_cnt_en & (bit_idx == L2W'(W - 1));

   // Port 0 in the first cycle after fill, port 1 in the second
   assign ram.wen   = (wtrig0 & wen0_q) | (wtrig1 & wen1_q);
   assign ram.waddr = wtrig1 ? wrow1 : wrow0;
   assign ram.wdata = wtrig1 ? wword1 : wsr0;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rreq_q  <= 1'b0;
         o_ready <= 1'b0;
         cnt     <= '0;
         rtrig0  <= 1'b0;
         rtrig1  <= 1'b0;
         wtrig0  <= 1'b0;
         wtrig1  <= 1'b0;
         wen0_q  <= 1'b0;
         wen1_q  <= 1'b0;
      end else begin
         // Ready two cycles after the request
         rreq_q  <= i_rreq;
         o_ready <= rreq_q;
         rtrig0  <= rd_issue0;
         rtrig1  <= rd_issue1;
         wtrig0  <= wr_fill;
         wtrig1  <= wtrig0;
         // Wraps back to zero after XLEN bits
         if (i_cnt_en) begin
            cnt <= cnt + 1'b1;
         end
         if (wr_fill) begin
            wen0_q <= rf.wen0;
            wen1_q <= rf.wen1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      // Serial write bits enter at the top
      if (i_cnt_en) begin
         wsr0 <= {rf.wdata0, wsr0[W-1:1]};
         wsr1 <= {rf.wdata1, wsr1[W-1:1]};
      end
      // Hold row and port 1 word until written
      if (wr_fill) begin
         wrow0  <= row(rf.wreg0, word_idx);
         wrow1  <= row(rf.wreg1, word_idx);
         wword1 <= {rf.wdata1, wsr1[W-1:1]};
      end
      // Read words shift out LSB first
      if (rtrig0) begin
         rdata0_q <= ram.rdata;
      end else if (i_cnt_en) begin
         rdata0_q <= rdata0_q >> 1;
      end
      // Bit 0 already used this cycle
      if (rtrig1) begin
         rdata1_q <= ram.rdata >> 1;
      end else if (i_cnt_en) begin
         rdata1_q <= rdata1_q >> 1;
      end
   end

endmodule

//--- design/rf_ram.sv
module rf_ram
   import rf_pkg::*;
#(
   parameter int W = 4
) (
   input  logic   i_clk,
   rf_ram_bus.mem ram
);

   localparam int DEPTH = ram_words(W);

   // All registers start at zero
   logic [W-1:0] mem [DEPTH] = '{default: '0};

   always_ff @(posedge i_clk) begin
      if (ram.wen) begin
         mem[ram.waddr] <= ram.wdata;
      end
      // Registered read, old data on a same-row write
      ram.rdata <= mem[ram.raddr];
   end

endmodule

//--- design/rf_top.sv
module rf_top #(
   parameter int WITH_CSR = 1,
   parameter int W        = 4
) (
   input  logic       i_clk,
   input  logic       i_reset,
   // Access handshake
   input  logic       i_rreq,
   output logic       o_ready,
   input  logic       i_cnt_en,
   // Trap entry and return
   input  logic       i_trap,
   input  logic       i_mret,
   input  logic       i_mepc,
   input  logic       i_mem_op,
   input  logic       i_bufreg_q,
   input  logic       i_bad_pc,
   output logic       o_csr_pc,
   // CSR access
   input  logic       i_csr_en,
   input  logic [1:0] i_csr_addr,
   input  logic       i_csr,
   output logic       o_csr,
   // rd writeback
   input  logic       i_rd_wen,
   input  logic [4:0] i_rd_waddr,
   input  logic       i_ctrl_rd,
   input  logic       i_alu_rd,
   input  logic       i_rd_alu_en,
   input  logic       i_csr_rd,
   input  logic       i_rd_csr_en,
   input  logic       i_mem_rd,
   // Source registers
   input  logic [4:0] i_rs1_raddr,
   output logic       o_rs1,
   input  logic [4:0] i_rs2_raddr,
   output logic       o_rs2
);

   // Serial ports and word RAM access
   rf_port_bus          port_bus ();
   rf_ram_bus #(.W(W))  ram_bus ();

   serv_rf_if #(
      .WITH_CSR (WITH_CSR)
   ) serv_rf_if_i (
      .i_cnt_en    (i_cnt_en),
      .i_trap      (i_trap),
      .i_mret      (i_mret),
      .i_mepc      (i_mepc),
      .i_mem_op    (i_mem_op),
      .i_bufreg_q  (i_bufreg_q),
      .i_bad_pc    (i_bad_pc),
      .o_csr_pc    (o_csr_pc),
      .i_csr_en    (i_csr_en),
      .i_csr_addr  (i_csr_addr),
      .i_csr       (i_csr),
      .o_csr       (o_csr),
      .i_rd_wen    (i_rd_wen),
      .i_rd_waddr  (i_rd_waddr),
      .i_ctrl_rd   (i_ctrl_rd),
      .i_alu_rd    (i_alu_rd),
      .i_rd_alu_en (i_rd_alu_en),
      .i_csr_rd    (i_csr_rd),
      .i_rd_csr_en (i_rd_csr_en),
      .i_mem_rd    (i_mem_rd),
      .i_rs1_raddr (i_rs1_raddr),
      .o_rs1       (o_rs1),
      .i_rs2_raddr (i_rs2_raddr),
      .o_rs2       (o_rs2),
      .rf          (port_bus.core)
   );

   rf_ram_if #(
      .W        (W),
      .WITH_CSR (WITH_CSR)
   ) rf_ram_if_i (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_rreq   (i_rreq),
      .i_cnt_en (i_cnt_en),
      .o_ready  (o_ready),
      .rf       (port_bus.ram),
      .ram      (ram_bus.ctrl)
   );

   rf_ram #(
      .W (W)
   ) rf_ram_i (
      .i_clk (i_clk),
      .ram   (ram_bus.mem)
   );

endmodule

//--- sim/tb_rf_top.sv
module tb_rf_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NREGS         = 36;
   localparam int NBITS         = 32;
   localparam int READY_TIMEOUT = 8;
   // Register numbers of the CSRs in the model
   localparam int CSR_REG0      = 32;
   localparam int MTVEC_REG     = 33;
   localparam int MEPC_REG      = 34;
   localparam int MTVAL_REG     = 35;

   logic       i_clk = 1'b0;
   logic       i_reset;
   logic       i_rreq;
   logic       o_ready;
   logic       i_cnt_en;
   logic       i_trap;
   logic       i_mret;
   logic       i_mepc;
   logic       i_mem_op;
   logic       i_bufreg_q;
   logic       i_bad_pc;
   logic       o_csr_pc;
   logic       i_csr_en;
   logic [1:0] i_csr_addr;
   logic       i_csr;
   logic       o_csr;
   logic       i_rd_wen;
   logic [4:0] i_rd_waddr;
   logic       i_ctrl_rd;
   logic       i_alu_rd;
   logic       i_rd_alu_en;
   logic       i_csr_rd;
   logic       i_rd_csr_en;
   logic       i_mem_rd;
   logic [4:0] i_rs1_raddr;
   logic       o_rs1;
   logic [4:0] i_rs2_raddr;
   logic       o_rs2;

   // Reference register file, CSRs from index 32 up
   logic [31:0] model [NREGS];
   logic [31:0] rng_state = 32'h3b344e0a;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_errors = 0;
   int          test_txns = 0;

   rf_top #(.WITH_CSR(1), .W(4)) dut_i (.*);

   always #10 i_clk = ~i_clk;

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      // Low state bits repeat with short periods, mix in the high half
      return rng_state ^ (rng_state >> 16);
   endfunction

   // Register seen on read port 1
   // trap, then mret, then CSR access, then rs2
   function automatic int read_port1_index();
      if (i_trap) return MTVEC_REG;
      if (i_mret) return MEPC_REG;
      if (i_csr_en) return CSR_REG0 + int'(i_csr_addr);
      return int'(i_rs2_raddr);
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         $display("ERROR %s expected %h got %h", name, exp, got);
         errors++;
         test_errors++;
      end
   endtask

   // Idle core, all controls and data low
   task automatic clear_controls();
      i_trap      = 1'b0;
      i_mret      = 1'b0;
      i_mepc      = 1'b0;
      i_mem_op    = 1'b0;
      i_bufreg_q  = 1'b0;
      i_bad_pc    = 1'b0;
      i_csr_en    = 1'b0;
      i_csr_addr  = 2'd0;
      i_csr       = 1'b0;
      i_rd_wen    = 1'b0;
      i_rd_waddr  = 5'd0;
      i_ctrl_rd   = 1'b0;
      i_alu_rd    = 1'b0;
      i_rd_alu_en = 1'b0;
      i_csr_rd    = 1'b0;
      i_rd_csr_en = 1'b0;
      i_mem_rd    = 1'b0;
      i_rs1_raddr = 5'd0;
      i_rs2_raddr = 5'd0;
   endtask

   // One full access with the controls already set up
   task automatic run_transaction();
      logic [31:0] sel;
      logic [31:0] s_ctrl, s_alu, s_csrrd, s_mem, s_csr, s_mepc, s_buf, s_bad;
      logic [31:0] got_rs1, got_rs2, got_csr, got_pc;
      logic [31:0] rd_val;
      int          p1;
      int          waits;
      // Serial data streams, some rd sources idle
      sel     = next_random();
      s_ctrl  = sel[0] ? next_random() : 32'h0;
      s_mem   = sel[1] ? next_random() : 32'h0;
      s_alu   = next_random();
      s_csrrd = next_random();
      s_csr   = next_random();
      s_mepc  = next_random();
      s_buf   = next_random();
      s_bad   = next_random();
      got_rs1 = '0;
      got_rs2 = '0;
      got_csr = '0;
      got_pc  = '0;
      waits   = 0;
      p1      = read_port1_index();
      test_txns++;
      @(negedge i_clk);
      i_rreq = 1'b1;
      do begin
         @(negedge i_clk);
         i_rreq = 1'b0;
         waits++;
      end while (!o_ready && waits < READY_TIMEOUT);
      checks++;
      assert (o_ready) else begin
         $display("o_ready did not rise within %0d cycles of the request", READY_TIMEOUT);
         errors++;
         test_errors++;
         return;
      end
      checks++;
      assert (waits == 2) else begin
         $display("o_ready came %0d cycles after the request instead of 2", waits);
         errors++;
         test_errors++;
      end
      for (int k = 0; k < NBITS; k++) begin
         @(negedge i_clk);
         // Outputs settled since the rising edge
         got_rs1[k] = o_rs1;
         got_rs2[k] = o_rs2;
         got_csr[k] = o_csr;
         got_pc[k]  = o_csr_pc;
         if (k == 0) begin
            checks++;
            assert (!o_ready) else begin
               $display("o_ready stayed high for more than one cycle");
               errors++;
               test_errors++;
            end
         end
         i_cnt_en   = 1'b1;
         i_ctrl_rd  = s_ctrl[k];
         i_alu_rd   = s_alu[k];
         i_csr_rd   = s_csrrd[k];
         i_mem_rd   = s_mem[k];
         i_csr      = s_csr[k];
         i_mepc     = s_mepc[k];
         i_bufreg_q = s_buf[k];
         i_bad_pc   = s_bad[k];
      end
      @(negedge i_clk);
      i_cnt_en = 1'b0;
      // Reads always see the values from before this access
      check_word("o_rs1", model[i_rs1_raddr], got_rs1);
      check_word("o_rs2", model[p1], got_rs2);
      check_word("o_csr", i_csr_en ? model[p1] : 32'h0, got_csr);
      if (i_trap || i_mret) begin
         check_word("o_csr_pc", model[p1], got_pc);
      end
      rd_val = s_ctrl | (s_alu & {32{i_rd_alu_en}}) | (s_csrrd & {32{i_rd_csr_en}}) | s_mem;
      if (i_trap) begin
         // Trap replaces rd and CSR writes
         model[MTVAL_REG] = i_mem_op ? s_buf : s_bad;
         model[MEPC_REG]  = s_mepc;
      end else begin
         if (i_rd_wen && i_rd_waddr != 5'd0) begin
            model[i_rd_waddr] = rd_val;
         end
         if (i_csr_en) begin
            model[CSR_REG0 + int'(i_csr_addr)] = s_csr;
         end
      end
      // Gap so the last words reach the RAM
      repeat (2) @(negedge i_clk);
   endtask

   task automatic end_test(input string name);
      $display("test %s: %0d transactions, %0d errors", name, test_txns, test_errors);
      tests++;
      test_txns   = 0;
      test_errors = 0;
   endtask

   initial begin
      logic [31:0] r;
      logic [4:0]  last_rd;
      logic [4:0]  reg_sel;
      i_reset  = 1'b1;
      i_rreq   = 1'b0;
      i_cnt_en = 1'b0;
      clear_controls();
      for (int i = 0; i < NREGS; i++) begin
         model[i] = '0;
      end
      repeat (5) @(negedge i_clk);
      i_reset = 1'b0;

      // GPR writes, rs1 reads back the previous rd
      last_rd = 5'd1;
      for (int n = 0; n < 40; n++) begin
         r = next_random();
         clear_controls();
         i_rd_wen    = r[0] | r[1];
         i_rd_alu_en = r[2];
         i_rd_csr_en = r[3];
         i_rd_waddr  = r[8:4];
         i_rs1_raddr = last_rd;
         i_rs2_raddr = r[14:10];
         run_transaction();
         last_rd = i_rd_waddr;
      end
      end_test("gpr");

      // x0 written with nonzero data must stay zero
      for (int n = 0; n < 5; n++) begin
         clear_controls();
         i_rd_wen    = 1'b1;
         i_rd_alu_en = 1'b1;
         run_transaction();
      end
      end_test("x0");

      for (int n = 0; n < 16; n++) begin
         r = next_random();
         clear_controls();
         i_csr_en    = 1'b1;
         i_csr_addr  = r[1:0];
         i_rd_wen    = r[2];
         i_rd_csr_en = 1'b1;
         i_rd_waddr  = r[8:4];
         i_rs1_raddr = r[13:9];
         run_transaction();
      end
      end_test("csr");

      // Trap with rd write requested, then read rd and MTVAL or MEPC
      for (int n = 0; n < 8; n++) begin
         r = next_random();
         reg_sel = r[8:4] | 5'd1;
         clear_controls();
         i_trap      = 1'b1;
         i_mem_op    = r[0];
         i_rd_wen    = 1'b1;
         i_rd_alu_en = 1'b1;
         i_rd_waddr  = reg_sel;
         i_rs1_raddr = reg_sel;
         run_transaction();
         clear_controls();
         i_csr_en    = 1'b1;
         i_csr_addr  = n[0] ? 2'd3 : 2'd2;
         i_rs1_raddr = reg_sel;
         run_transaction();
      end
      end_test("trap");

      for (int n = 0; n < 6; n++) begin
         r = next_random();
         clear_controls();
         i_trap   = 1'b1;
         i_mem_op = r[0];
         run_transaction();
         clear_controls();
         i_mret      = 1'b1;
         i_rs1_raddr = r[8:4];
         run_transaction();
      end
      end_test("mret");

      // Read and write one register, old value first, new value next
      for (int n = 0; n < 8; n++) begin
         r = next_random();
         reg_sel = r[4:0] | 5'd1;
         clear_controls();
         i_rs1_raddr = reg_sel;
         i_rs2_raddr = reg_sel;
         if (n[0]) begin
            i_csr_en   = 1'b1;
            i_csr_addr = r[6:5];
         end else begin
            i_rd_wen    = 1'b1;
            i_rd_alu_en = 1'b1;
            i_rd_waddr  = reg_sel;
         end
         run_transaction();
         i_rd_wen = 1'b0;
         run_transaction();
      end
      end_test("ordering");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- sim.f
design/rf_pkg.sv
design/rf_ifs.sv
design/serv_rf_if.sv
design/rf_ram_if.sv
design/rf_ram.sv
design/rf_top.sv
sim/tb_rf_top.sv

//--- Bender.yml
package:
  name: serv_rf

sources:
  - design/rf_pkg.sv
  - design/rf_ifs.sv
  - design/serv_rf_if.sv
  - design/rf_ram_if.sv
  - design/rf_ram.sv
  - design/rf_top.sv
  - target: simulation
    files:
      - sim/tb_rf_top.sv
